/* hdl/axi_mem_pkg.sv */
`default_nettype none

package axi_mem_pkg;

  // AXI bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;

  // AXI len field holds the number of beats minus one
  localparam int LEN_W  = 8;

  // Byte offset bits inside one bus word
  localparam int OFFS_W = $clog2(STRB_W);

  // Only response ever returned on B and R
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // One byte address, seen either flat or as word index plus byte offset.
  // The flat view goes on the bus ports, the split view steps bursts and indexes the RAM
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    struct packed {
      logic [ADDR_W-OFFS_W-1:0] word;
      logic [OFFS_W-1:0]        offs;
    } split;
  } mem_addr_t;

endpackage

`default_nettype wire

/* hdl/burst_if.sv */
`default_nettype none

interface burst_if import axi_mem_pkg::*; ();

  // Burst setup and beat stepping
  logic             load;
  mem_addr_t        start_addr;
  logic [LEN_W-1:0] len;
  logic [ID_W-1:0]  id;
  logic             step;

  // Current beat of the active burst
  mem_addr_t        addr;
  logic [LEN_W-1:0] beat_count;
  logic             last;
  logic [ID_W-1:0]  id_q;

  modport seq (
    output load, start_addr, len, id, step,
    input  last
  );

  modport cnt (
    input  load, start_addr, len, id, step,
    output addr, beat_count, last, id_q
  );

  modport data (
    input addr, beat_count, last, id_q
  );

endinterface

`default_nettype wire

/* hdl/burst_sequencer.sv */
`default_nettype none

module burst_sequencer import axi_mem_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              aw_valid_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic [ID_W-1:0]   aw_id_i,
  input  logic [LEN_W-1:0]  aw_len_i,
  output logic              aw_ready_o,
  input  logic              ar_valid_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  input  logic [ID_W-1:0]   ar_id_i,
  input  logic [LEN_W-1:0]  ar_len_i,
  output logic              ar_ready_o,
  input  logic              w_valid_i,
  input  logic [STRB_W-1:0] w_strb_i,
  input  logic              w_last_i,
  output logic              w_ready_o,
  output logic              b_valid_o,
  output logic [ID_W-1:0]   b_id_o,
  output logic [1:0]        b_resp_o,
  input  logic              b_ready_i,
  input  logic              buf_free_i,
  output logic              ram_we_o,
  output logic              ram_re_o,
  output logic [STRB_W-1:0] w_strb_o,
  burst_if.seq              bus
);

  localparam logic [1:0] IDLE  = 2'd0;
  localparam logic [1:0] WRITE = 2'd1;
  localparam logic [1:0] RESP  = 2'd2;
  localparam logic [1:0] READ  = 2'd3;

  logic [1:0]      state_q;
  logic            rd_served_q;
  logic            rd_busy_q;
  logic [ID_W-1:0] b_id_q;
  logic            aw_fire;
  logic            ar_fire;
  logic            w_fire;
  logic            rd_step;

  assign aw_fire   = aw_valid_i && aw_ready_o;
  assign ar_fire   = ar_valid_i && ar_ready_o;
  assign w_ready_o = (state_q == WRITE);
  assign w_fire    = w_valid_i && w_ready_o;
  assign b_valid_o = (state_q == RESP);
  assign b_id_o    = b_id_q;
  assign b_resp_o  = RESP_OKAY;
  assign ram_we_o  = w_fire;
  assign w_strb_o  = w_strb_i;

  // One read beat in flight; buffer empty again means the beat was taken
  assign ram_re_o = (state_q == READ) && buf_free_i && !rd_busy_q;
  assign rd_step  = (state_q == READ) && buf_free_i && rd_busy_q;

  assign bus.load            = aw_fire || ar_fire;
  assign bus.start_addr.flat = aw_fire ? aw_addr_i : ar_addr_i;
  assign bus.len             = aw_fire ? aw_len_i : ar_len_i;
  assign bus.id              = aw_fire ? aw_id_i : ar_id_i;
  assign bus.step            = w_fire || rd_step;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      aw_ready_o  <= 1'b0;
      ar_ready_o  <= 1'b0;
      rd_served_q <= 1'b1;  // write wins the first grant
      rd_busy_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (aw_fire) begin
            aw_ready_o  <= 1'b0;
            rd_served_q <= 1'b0;
            state_q     <= WRITE;
          end else if (ar_fire) begin
            ar_ready_o  <= 1'b0;
            rd_served_q <= 1'b1;
            state_q     <= READ;
          end else if (!aw_ready_o && !ar_ready_o) begin
            // Alternate when both channels wait
            if (aw_valid_i && (!ar_valid_i || rd_served_q)) begin
              aw_ready_o <= 1'b1;
            end else if (ar_valid_i) begin
              ar_ready_o <= 1'b1;
            end
          end
        end
        WRITE: begin
          if (w_fire && bus.last) state_q <= RESP;
        end
        RESP: begin
          if (b_ready_i) state_q <= IDLE;
        end
        default: begin
          if (ram_re_o) begin
            rd_busy_q <= 1'b1;
          end else if (rd_step) begin
            rd_busy_q <= 1'b0;
            if (bus.last) state_q <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) b_id_q <= aw_id_i;
  end

  // Master's W last must line up with the length latched from AW
  a_w_last_match: assert property (@(posedge clk_i) disable iff (rst_i)
    w_fire |-> (w_last_i == bus.last))
    else $error("W last flag does not match the AW burst length");

endmodule

`default_nettype wire

/* hdl/beat_counter.sv */
`default_nettype none

module beat_counter import axi_mem_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  burst_if.cnt bus
);

  mem_addr_t        addr_q;
  logic [LEN_W-1:0] len_q;
  logic [LEN_W-1:0] count_q;
  logic [ID_W-1:0]  id_q;

  // Address and id of the burst
  always_ff @(posedge clk_i) begin
    if (bus.load) begin
      addr_q <= bus.start_addr;
      id_q   <= bus.id;
    end else if (bus.step) begin
      // INCR: next word, aligned from the second beat on
      addr_q.split.word <= addr_q.split.word + 1'b1;
      addr_q.split.offs <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      len_q   <= '0;
      count_q <= '0;
    end else if (bus.load) begin
      len_q   <= bus.len;
      count_q <= '0;
    end else if (bus.step) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign bus.addr       = addr_q;
  assign bus.beat_count = count_q;
  assign bus.last       = (count_q == len_q);
  assign bus.id_q       = id_q;

  // Once the final beat has been stepped, nothing steps until the next burst is loaded
  a_no_step_past_last: assert property (@(posedge clk_i) disable iff (rst_i)
    (bus.step && bus.last) |=> (!bus.step until bus.load))
    else $error("Beat step after the last beat of the burst");

endmodule

`default_nettype wire

/* hdl/mem_array.sv */
`default_nettype none

module mem_array import axi_mem_pkg::*; #(
  parameter int MemWords = 256
) (
  input  logic              clk_i,
  input  logic              we_i,
  input  logic              re_i,
  input  logic [STRB_W-1:0] strb_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o,
  burst_if.data             bus
);

  localparam int IDX_W = $clog2(MemWords);

  logic [DATA_W-1:0] mem_q [MemWords];
  logic [IDX_W-1:0]  idx;

  // Upper word index bits drop, so addresses wrap modulo the depth
  assign idx = bus.addr.split.word[IDX_W-1:0];

  // Byte lane writes
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb_i[b]) begin
          mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Registered read port, holds until the next read
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[idx];
    end
  end

endmodule

`default_nettype wire

/* hdl/read_beat_buffer.sv */
`default_nettype none

module read_beat_buffer import axi_mem_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              fill_i,
  input  logic [DATA_W-1:0] rdata_i,
  input  logic              r_ready_i,
  output logic              buf_free_o,
  output logic              r_valid_o,
  output logic [DATA_W-1:0] r_data_o,
  output logic [ID_W-1:0]   r_id_o,
  output logic [1:0]        r_resp_o,
  output logic              r_last_o,
  burst_if.data             bus
);

  logic pend_q;

  // RAM word lands one edge after the read, take it on the edge after that
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q    <= 1'b0;
      r_valid_o <= 1'b0;
    end else begin
      pend_q <= fill_i;
      if (pend_q) begin
        r_valid_o <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pend_q) begin
      r_data_o <= rdata_i;
      r_id_o   <= bus.id_q;
      r_last_o <= bus.last;
    end
  end

  assign buf_free_o = !pend_q && !r_valid_o;
  assign r_resp_o   = RESP_OKAY;

  // A stalled beat keeps valid and its payload
  a_r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (r_valid_o && !r_ready_i) |=>
      (r_valid_o && $stable(r_data_o) && $stable(r_id_o) && $stable(r_last_o)))
    else $error("R beat changed while stalled");

endmodule

`default_nettype wire

/* hdl/beat_monitor.sv */
`default_nettype none

module beat_monitor import axi_mem_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              w_fire_i,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic              r_fire_i,
  input  logic [DATA_W-1:0] r_data_i,
  output logic              mon_w_valid_o,
  output logic [ADDR_W-1:0] mon_w_addr_o,
  output logic [DATA_W-1:0] mon_w_data_o,
  output logic [ID_W-1:0]   mon_w_id_o,
  output logic [LEN_W-1:0]  mon_w_beat_count_o,
  output logic              mon_w_last_o,
  output logic              mon_r_valid_o,
  output logic [ADDR_W-1:0] mon_r_addr_o,
  output logic [DATA_W-1:0] mon_r_data_o,
  output logic [ID_W-1:0]   mon_r_id_o,
  output logic [LEN_W-1:0]  mon_r_beat_count_o,
  output logic              mon_r_last_o,
  burst_if.data             bus
);

  // One-cycle pulse after each handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mon_w_valid_o <= 1'b0;
      mon_r_valid_o <= 1'b0;
    end else begin
      mon_w_valid_o <= w_fire_i;
      mon_r_valid_o <= r_fire_i;
    end
  end

  // Counter still shows the handshaking beat at this edge
  always_ff @(posedge clk_i) begin
    if (w_fire_i) begin
      mon_w_addr_o       <= bus.addr.flat;
      mon_w_data_o       <= w_data_i;
      mon_w_id_o         <= bus.id_q;
      mon_w_beat_count_o <= bus.beat_count;
      mon_w_last_o       <= bus.last;
    end
    if (r_fire_i) begin
      mon_r_addr_o       <= bus.addr.flat;
      mon_r_data_o       <= r_data_i;
      mon_r_id_o         <= bus.id_q;
      mon_r_beat_count_o <= bus.beat_count;
      mon_r_last_o       <= bus.last;
    end
  end

endmodule

`default_nettype wire

/* hdl/axi_mem_top.sv */
`default_nettype none

module axi_mem_top import axi_mem_pkg::*; #(
  parameter int MemWords = 256
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // AW
  input  logic              aw_valid_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic [ID_W-1:0]   aw_id_i,
  input  logic [LEN_W-1:0]  aw_len_i,
  output logic              aw_ready_o,
  // W
  input  logic              w_valid_i,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  input  logic              w_last_i,
  output logic              w_ready_o,
  // B
  output logic              b_valid_o,
  output logic [ID_W-1:0]   b_id_o,
  output logic [1:0]        b_resp_o,
  input  logic              b_ready_i,
  // AR
  input  logic              ar_valid_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  input  logic [ID_W-1:0]   ar_id_i,
  input  logic [LEN_W-1:0]  ar_len_i,
  output logic              ar_ready_o,
  // R
  output logic              r_valid_o,
  output logic [DATA_W-1:0] r_data_o,
  output logic [ID_W-1:0]   r_id_o,
  output logic [1:0]        r_resp_o,
  output logic              r_last_o,
  input  logic              r_ready_i,
  // Write monitor
  output logic              mon_w_valid_o,
  output logic [ADDR_W-1:0] mon_w_addr_o,
  output logic [DATA_W-1:0] mon_w_data_o,
  output logic [ID_W-1:0]   mon_w_id_o,
  output logic [LEN_W-1:0]  mon_w_beat_count_o,
  output logic              mon_w_last_o,
  // Read monitor
  output logic              mon_r_valid_o,
  output logic [ADDR_W-1:0] mon_r_addr_o,
  output logic [DATA_W-1:0] mon_r_data_o,
  output logic [ID_W-1:0]   mon_r_id_o,
  output logic [LEN_W-1:0]  mon_r_beat_count_o,
  output logic              mon_r_last_o
);

  logic              ram_we;
  logic              ram_re;
  logic [STRB_W-1:0] ram_strb;
  logic [DATA_W-1:0] ram_rdata;
  logic              buf_free;
  logic              w_fire;
  logic              r_fire;

  burst_if bus ();

  assign w_fire = w_valid_i && w_ready_o;
  assign r_fire = r_valid_o && r_ready_i;

  burst_sequencer u_seq (
    .clk_i, .rst_i,
    .aw_valid_i, .aw_addr_i, .aw_id_i, .aw_len_i, .aw_ready_o,
    .ar_valid_i, .ar_addr_i, .ar_id_i, .ar_len_i, .ar_ready_o,
    .w_valid_i, .w_strb_i, .w_last_i, .w_ready_o,
    .b_valid_o, .b_id_o, .b_resp_o, .b_ready_i,
    .buf_free_i (buf_free),
    .ram_we_o   (ram_we),
    .ram_re_o   (ram_re),
    .w_strb_o   (ram_strb),
    .bus        (bus.seq)
  );

  beat_counter u_cnt (
    .clk_i, .rst_i,
    .bus (bus.cnt)
  );

  mem_array #(
    .MemWords (MemWords)
  ) u_mem (
    .clk_i,
    .we_i    (ram_we),
    .re_i    (ram_re),
    .strb_i  (ram_strb),
    .wdata_i (w_data_i),
    .rdata_o (ram_rdata),
    .bus     (bus.data)
  );

  read_beat_buffer u_rbuf (
    .clk_i, .rst_i,
    .fill_i     (ram_re),
    .rdata_i    (ram_rdata),
    .r_ready_i,
    .buf_free_o (buf_free),
    .r_valid_o, .r_data_o, .r_id_o, .r_resp_o, .r_last_o,
    .bus        (bus.data)
  );

  beat_monitor u_mon (
    .clk_i, .rst_i,
    .w_fire_i (w_fire),
    .w_data_i,
    .r_fire_i (r_fire),
    .r_data_i (r_data_o),
    .mon_w_valid_o, .mon_w_addr_o, .mon_w_data_o,
    .mon_w_id_o, .mon_w_beat_count_o, .mon_w_last_o,
    .mon_r_valid_o, .mon_r_addr_o, .mon_r_data_o,
    .mon_r_id_o, .mon_r_beat_count_o, .mon_r_last_o,
    .bus      (bus.data)
  );

endmodule

`default_nettype wire

/* tb/axi_mem_checker.sv */
`default_nettype none

module axi_mem_checker import axi_mem_pkg::*; #(
  parameter int MemWords = 256,
  parameter int NameBits = 80
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [NameBits-1:0] test_name_i,
  input  logic                aw_valid_i,
  input  logic [ADDR_W-1:0]   aw_addr_i,
  input  logic [ID_W-1:0]     aw_id_i,
  input  logic [LEN_W-1:0]    aw_len_i,
  input  logic                aw_ready_o,
  input  logic                w_valid_i,
  input  logic [DATA_W-1:0]   w_data_i,
  input  logic [STRB_W-1:0]   w_strb_i,
  input  logic                w_ready_o,
  input  logic                b_valid_o,
  input  logic [ID_W-1:0]     b_id_o,
  input  logic [1:0]          b_resp_o,
  input  logic                b_ready_i,
  input  logic                ar_valid_i,
  input  logic [ADDR_W-1:0]   ar_addr_i,
  input  logic [ID_W-1:0]     ar_id_i,
  input  logic [LEN_W-1:0]    ar_len_i,
  input  logic                ar_ready_o,
  input  logic                r_valid_o,
  input  logic [DATA_W-1:0]   r_data_o,
  input  logic [ID_W-1:0]     r_id_o,
  input  logic [1:0]          r_resp_o,
  input  logic                r_last_o,
  input  logic                r_ready_i,
  input  logic                mon_w_valid_o,
  input  logic [ADDR_W-1:0]   mon_w_addr_o,
  input  logic [DATA_W-1:0]   mon_w_data_o,
  input  logic [ID_W-1:0]     mon_w_id_o,
  input  logic [LEN_W-1:0]    mon_w_beat_count_o,
  input  logic                mon_w_last_o,
  input  logic                mon_r_valid_o,
  input  logic [ADDR_W-1:0]   mon_r_addr_o,
  input  logic [DATA_W-1:0]   mon_r_data_o,
  input  logic [ID_W-1:0]     mon_r_id_o,
  input  logic [LEN_W-1:0]    mon_r_beat_count_o,
  input  logic                mon_r_last_o,
  output int                  checks_o,
  output int                  errors_o
);

  // One beat as the monitor reports it
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
    logic [LEN_W-1:0]  count;
    logic              last;
  } beat_t;

  logic [7:0]          ref_bytes [MemWords*STRB_W];
  logic [NameBits-1:0] burst_name;
  logic                seen_addr;
  logic                in_write;
  logic                in_read;
  logic [ADDR_W-1:0]   cur_addr;
  logic [ID_W-1:0]     cur_id;
  logic [LEN_W-1:0]    cur_len;
  int                  beat_k;
  logic                exp_mw_valid;
  logic                exp_mr_valid;
  beat_t               exp_w;
  beat_t               exp_r;
  logic                stall_q;
  logic [DATA_W-1:0]   stall_data;
  logic [ID_W-1:0]     stall_id;
  logic                stall_last;

  initial begin
    for (int i = 0; i < MemWords * STRB_W; i++) begin
      ref_bytes[i] = 8'h00;
    end
    seen_addr    = 1'b0;
    in_write     = 1'b0;
    in_read      = 1'b0;
    exp_mw_valid = 1'b0;
    exp_mr_valid = 1'b0;
    stall_q      = 1'b0;
    beat_k       = 0;
    burst_name   = '0;
    checks_o     = 0;
    errors_o     = 0;
  end

  task automatic check_value(input string what, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    checks_o++;
    if (exp !== act) begin
      errors_o++;
      $display("FAILED %0s: %0s expected %h actual %h", burst_name, what, exp, act);
    end
  endtask

  task automatic flag_error(input string msg);
    errors_o++;
    $display("ERROR in %0s: %0s", burst_name, msg);
  endtask

  // INCR rule: first beat at the start address, later beats on the following aligned words
  function automatic logic [ADDR_W-1:0] beat_address(input logic [ADDR_W-1:0] start,
                                                     input int k);
    logic [ADDR_W-OFFS_W-1:0] word;
    if (k == 0) begin
      return start;
    end
    word = start[ADDR_W-1:OFFS_W] + (ADDR_W-OFFS_W)'(k);
    return {word, {OFFS_W{1'b0}}};
  endfunction

  function automatic int ram_index(input logic [ADDR_W-1:0] addr);
    return int'(addr[ADDR_W-1:OFFS_W]) % MemWords;
  endfunction

  function automatic logic [DATA_W-1:0] stored_word(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] w;
    for (int lane = 0; lane < STRB_W; lane++) begin
      w[lane*8 +: 8] = ref_bytes[ram_index(addr)*STRB_W + lane];
    end
    return w;
  endfunction

  task automatic check_monitor(input string side, input logic exp_valid, input beat_t exp,
                               input logic act_valid, input beat_t act);
    check_value({side, " valid"}, DATA_W'(exp_valid), DATA_W'(act_valid));
    if (exp_valid && act_valid) begin
      check_value({side, " addr"}, DATA_W'(exp.addr), DATA_W'(act.addr));
      check_value({side, " data"}, exp.data, act.data);
      check_value({side, " id"}, DATA_W'(exp.id), DATA_W'(act.id));
      check_value({side, " beat count"}, DATA_W'(exp.count), DATA_W'(act.count));
      check_value({side, " last"}, DATA_W'(exp.last), DATA_W'(act.last));
    end
  endtask

  task automatic start_burst(input logic is_write, input logic [ADDR_W-1:0] addr,
                             input logic [ID_W-1:0] id, input logic [LEN_W-1:0] len);
    if (in_write || in_read) begin
      flag_error("address accepted while a burst is still open");
    end
    seen_addr = 1'b1;
    in_write  = is_write;
    in_read   = !is_write;
    cur_addr  = addr;
    cur_id    = id;
    cur_len   = len;
    beat_k    = 0;
  endtask

  task automatic take_write_beat();
    logic [ADDR_W-1:0] a;
    if (!in_write || beat_k > int'(cur_len)) begin
      flag_error("W beat accepted outside a write burst");
    end else begin
      a = beat_address(cur_addr, beat_k);
      for (int lane = 0; lane < STRB_W; lane++) begin
        if (w_strb_i[lane]) begin
          ref_bytes[ram_index(a)*STRB_W + lane] = w_data_i[lane*8 +: 8];
        end
      end
      exp_mw_valid = 1'b1;
      exp_w = {a, w_data_i, cur_id, LEN_W'(beat_k), (beat_k == int'(cur_len))};
      beat_k++;
    end
  endtask

  task automatic take_write_response();
    if (!in_write || beat_k != int'(cur_len) + 1) begin
      flag_error("B response before the write burst completed");
    end else begin
      check_value("b_id", DATA_W'(cur_id), DATA_W'(b_id_o));
      check_value("b_resp", DATA_W'(RESP_OKAY), DATA_W'(b_resp_o));
    end
    in_write = 1'b0;
  endtask

  task automatic take_read_beat();
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic              last;
    if (!in_read) begin
      flag_error("R beat accepted outside a read burst");
    end else begin
      a    = beat_address(cur_addr, beat_k);
      d    = stored_word(a);
      last = (beat_k == int'(cur_len));
      check_value("r_data", d, r_data_o);
      check_value("r_id", DATA_W'(cur_id), DATA_W'(r_id_o));
      check_value("r_resp", DATA_W'(RESP_OKAY), DATA_W'(r_resp_o));
      check_value("r_last", DATA_W'(last), DATA_W'(r_last_o));
      exp_mr_valid = 1'b1;
      exp_r = {a, d, cur_id, LEN_W'(beat_k), last};
      if (last) begin
        in_read = 1'b0;
      end
      beat_k++;
    end
  endtask

  // Outputs settle well before the falling edge, and the transfers seen here
  // complete at the next rising edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (!in_write && !in_read && !exp_mw_valid && !exp_mr_valid) begin
        burst_name = test_name_i;
      end
      check_monitor("mon_w", exp_mw_valid, exp_w, mon_w_valid_o,
                    {mon_w_addr_o, mon_w_data_o, mon_w_id_o, mon_w_beat_count_o, mon_w_last_o});
      check_monitor("mon_r", exp_mr_valid, exp_r, mon_r_valid_o,
                    {mon_r_addr_o, mon_r_data_o, mon_r_id_o, mon_r_beat_count_o, mon_r_last_o});
      exp_mw_valid = 1'b0;
      exp_mr_valid = 1'b0;
      if (!seen_addr) begin
        check_value("w_ready before the first burst", '0, DATA_W'(w_ready_o));
        check_value("b_valid before the first burst", '0, DATA_W'(b_valid_o));
        check_value("r_valid before the first burst", '0, DATA_W'(r_valid_o));
      end
      if ((in_write || in_read) && (aw_ready_o || ar_ready_o)) begin
        flag_error("address channel ready while a burst is still open");
      end
      // Stalled R beat must hold
      if (stall_q) begin
        check_value("r_valid while stalled", DATA_W'(1'b1), DATA_W'(r_valid_o));
        check_value("r_data while stalled", stall_data, r_data_o);
        check_value("r_id while stalled", DATA_W'(stall_id), DATA_W'(r_id_o));
        check_value("r_last while stalled", DATA_W'(stall_last), DATA_W'(r_last_o));
      end
      if (aw_valid_i && aw_ready_o) begin
        start_burst(1'b1, aw_addr_i, aw_id_i, aw_len_i);
      end
      if (ar_valid_i && ar_ready_o) begin
        start_burst(1'b0, ar_addr_i, ar_id_i, ar_len_i);
      end
      if (w_valid_i && w_ready_o) begin
        take_write_beat();
      end
      if (b_valid_o && b_ready_i) begin
        take_write_response();
      end
      if (r_valid_o && r_ready_i) begin
        take_read_beat();
      end
      stall_q    = r_valid_o && !r_ready_i;
      stall_data = r_data_o;
      stall_id   = r_id_o;
      stall_last = r_last_o;
    end
  end

endmodule

`default_nettype wire

/* tb/tb_axi_mem.sv */
`default_nettype none

module tb_axi_mem import axi_mem_pkg::*; ();

  localparam int MEM_WORDS   = 256;
  localparam int NAME_W      = 80;
  localparam int NUM_ROWS    = 13;
  localparam int TIMEOUT     = 200;
  localparam int HALF_PERIOD = 10;
  localparam int DRIVE_DELAY = 2;
  localparam int CH_AW       = 0;
  localparam int CH_W        = 1;
  localparam int CH_B        = 2;
  localparam int CH_AR       = 3;
  localparam int CH_R        = 4;

  // One row of the stimulus table with a ten-character name
  typedef struct packed {
    logic [NAME_W-1:0] name;
    logic              is_write;
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] base;
  } burst_row_t;

  logic              clk_i;
  logic              rst_i;
  logic              aw_valid_i;
  logic [ADDR_W-1:0] aw_addr_i;
  logic [ID_W-1:0]   aw_id_i;
  logic [LEN_W-1:0]  aw_len_i;
  logic              aw_ready_o;
  logic              w_valid_i;
  logic [DATA_W-1:0] w_data_i;
  logic [STRB_W-1:0] w_strb_i;
  logic              w_last_i;
  logic              w_ready_o;
  logic              b_valid_o;
  logic [ID_W-1:0]   b_id_o;
  logic [1:0]        b_resp_o;
  logic              b_ready_i;
  logic              ar_valid_i;
  logic [ADDR_W-1:0] ar_addr_i;
  logic [ID_W-1:0]   ar_id_i;
  logic [LEN_W-1:0]  ar_len_i;
  logic              ar_ready_o;
  logic              r_valid_o;
  logic [DATA_W-1:0] r_data_o;
  logic [ID_W-1:0]   r_id_o;
  logic [1:0]        r_resp_o;
  logic              r_last_o;
  logic              r_ready_i;
  logic              mon_w_valid_o;
  logic [ADDR_W-1:0] mon_w_addr_o;
  logic [DATA_W-1:0] mon_w_data_o;
  logic [ID_W-1:0]   mon_w_id_o;
  logic [LEN_W-1:0]  mon_w_beat_count_o;
  logic              mon_w_last_o;
  logic              mon_r_valid_o;
  logic [ADDR_W-1:0] mon_r_addr_o;
  logic [DATA_W-1:0] mon_r_data_o;
  logic [ID_W-1:0]   mon_r_id_o;
  logic [LEN_W-1:0]  mon_r_beat_count_o;
  logic              mon_r_last_o;

  burst_row_t        rows [NUM_ROWS];
  logic [NAME_W-1:0] cur_name;
  logic              timed_out;
  logic [31:0]       rnd;
  int                check_count;
  int                error_count;

  axi_mem_top #(
    .MemWords (MEM_WORDS)
  ) UUT (.*);

  axi_mem_checker #(
    .MemWords (MEM_WORDS),
    .NameBits (NAME_W)
  ) u_checker (
    .test_name_i (cur_name),
    .checks_o    (check_count),
    .errors_o    (error_count),
    .*
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  function automatic logic transfer_now(input int ch);
    case (ch)
      CH_AW:   return aw_valid_i && aw_ready_o;
      CH_W:    return w_valid_i && w_ready_o;
      CH_B:    return b_valid_o && b_ready_i;
      CH_AR:   return ar_valid_i && ar_ready_o;
      default: return r_valid_o && r_ready_i;
    endcase
  endfunction

  // Returns one drive slot after the transfer
  // B and R readies stall at random while waiting
  task automatic await_transfer(input int ch, input string what);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && !timed_out) begin
      rnd = $urandom;
      if (ch == CH_B) begin
        b_ready_i = (rnd[1:0] != 2'b00);
      end else if (ch == CH_R) begin
        r_ready_i = (rnd[1:0] != 2'b00);
      end
      @(negedge clk_i);
      if (transfer_now(ch)) begin
        done = 1'b1;
      end else begin
        waited++;
        if (waited >= TIMEOUT) begin
          $display("Timeout: %0s never completed in test %0s", what, cur_name);
          timed_out = 1'b1;
        end
      end
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
  endtask

  task automatic post_address(input burst_row_t row);
    if (row.is_write) begin
      aw_valid_i = 1'b1;
      aw_addr_i  = row.addr;
      aw_id_i    = row.id;
      aw_len_i   = row.len;
    end else begin
      ar_valid_i = 1'b1;
      ar_addr_i  = row.addr;
      ar_id_i    = row.id;
      ar_len_i   = row.len;
    end
  endtask

  // Next burst's address waits on its channel while this burst is still open
  task automatic post_next_address(input int idx);
    if (idx + 1 < NUM_ROWS) begin
      post_address(rows[idx + 1]);
    end
  endtask

  task automatic run_write(input int idx);
    burst_row_t row;
    row = rows[idx];
    post_address(row);
    await_transfer(CH_AW, "AW address handshake");
    aw_valid_i = 1'b0;
    post_next_address(idx);
    for (int k = 0; k <= int'(row.len) && !timed_out; k++) begin
      w_valid_i = 1'b1;
      w_data_i  = row.base + DATA_W'(k);
      w_strb_i  = row.strb;
      w_last_i  = (LEN_W'(k) == row.len);
      await_transfer(CH_W, "W data beat");
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    await_transfer(CH_B, "B write response");
    b_ready_i = 1'b0;
  endtask

  task automatic run_read(input int idx);
    burst_row_t row;
    row = rows[idx];
    post_address(row);
    await_transfer(CH_AR, "AR address handshake");
    ar_valid_i = 1'b0;
    post_next_address(idx);
    for (int k = 0; k <= int'(row.len) && !timed_out; k++) begin
      await_transfer(CH_R, "R data beat");
    end
    r_ready_i = 1'b0;
  endtask

  // name, write, id, address, len, strobe, data base
  task automatic load_table();
    rows[0]  = '{"wr_single ", 1'b1, 4'd3,  16'h0040, 8'd0, 4'hF, 32'hA5A5_0000};
    rows[1]  = '{"rd_single ", 1'b0, 4'd5,  16'h0040, 8'd0, 4'h0, 32'h0000_0000};
    rows[2]  = '{"wr_full   ", 1'b1, 4'd1,  16'h0080, 8'd0, 4'hF, 32'h1122_3344};
    rows[3]  = '{"wr_strobe ", 1'b1, 4'd2,  16'h0080, 8'd0, 4'h5, 32'hCCDD_EEFF};
    rows[4]  = '{"rd_strobe ", 1'b0, 4'd6,  16'h0080, 8'd0, 4'h0, 32'h0000_0000};
    rows[5]  = '{"wr_burst  ", 1'b1, 4'd7,  16'h0100, 8'd7, 4'hF, 32'h1000_0000};
    rows[6]  = '{"rd_burst  ", 1'b0, 4'd8,  16'h0100, 8'd7, 4'h0, 32'h0000_0000};
    rows[7]  = '{"wr_wrap   ", 1'b1, 4'd9,  16'h0410, 8'd3, 4'hF, 32'h0BAD_0000};
    rows[8]  = '{"rd_wrap_lo", 1'b0, 4'd10, 16'h0010, 8'd3, 4'h0, 32'h0000_0000};
    rows[9]  = '{"rd_wrap_hi", 1'b0, 4'd11, 16'h0410, 8'd3, 4'h0, 32'h0000_0000};
    rows[10] = '{"wr_edge   ", 1'b1, 4'd12, 16'h03F8, 8'd3, 4'hF, 32'h7E00_0000};
    rows[11] = '{"rd_edge   ", 1'b0, 4'd13, 16'h03F8, 8'd3, 4'h0, 32'h0000_0000};
    rows[12] = '{"rd_mid    ", 1'b0, 4'd14, 16'h0106, 8'd3, 4'h0, 32'h0000_0000};
  endtask

  initial begin
    rst_i      = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    aw_len_i   = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    ar_len_i   = '0;
    r_ready_i  = 1'b0;
    cur_name   = '0;
    timed_out  = 1'b0;
    rnd        = $urandom(32'h552b_3de0);
    load_table();
    repeat (2) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b0;
    // Idle cycles so the checker sees the quiet outputs after reset
    repeat (3) @(posedge clk_i);
    #DRIVE_DELAY;
    for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
      cur_name = rows[i].name;
      if (rows[i].is_write) begin
        run_write(i);
      end else begin
        run_read(i);
      end
    end
    // Last monitor pulse reaches the checker one cycle after its handshake
    repeat (2) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d, timeout: %0d", check_count, error_count, timed_out);
    if (error_count == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hdl/axi_mem_pkg.sv
hdl/burst_if.sv
hdl/burst_sequencer.sv
hdl/beat_counter.sv
hdl/mem_array.sv
hdl/read_beat_buffer.sv
hdl/beat_monitor.sv
hdl/axi_mem_top.sv
tb/axi_mem_checker.sv
tb/tb_axi_mem.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module tb_axi_mem -Mdir obj_dir -f files.f \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_axi_mem > sim.log 2>&1
cat sim.log
grep -q "all tests passed" sim.log && exit 0 || exit 1
